//--- Makefile
TOP = tb_arcade_keyboard

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module arcade_keyboard \
		ps2_pkg.sv arcade_keys_pkg.sv key_event_if.sv ps2_rx.sv \
		ps2_scan_tracker.sv arcade_key_map.sv arcade_keyboard.sv

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f arcade_keyboard.f
	-./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" sim.log; then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- arcade_key_map.sv
// Key event to arcade control map
`default_nettype none

module arcade_key_map (
    input  wire                    clk,
    input  wire                    rst,
    key_event_if.dst               ev,
    output arcade_keys_pkg::joy_t  key_joy1,
    output arcade_keys_pkg::joy_t  key_joy2,
    output arcade_keys_pkg::pair_t key_start,
    output arcade_keys_pkg::pair_t key_coin,
    output logic                   key_pause,
    output arcade_keys_pkg::gfx_t  key_gfx
);

    logic level;   // Make sets, break clears

    assign level = !ev.released;

    always_ff @(posedge clk) begin
        if (rst) begin
            key_joy1  <= '0;
            key_joy2  <= '0;
            key_start <= '0;
            key_coin  <= '0;
            key_pause <= 1'b0;
            key_gfx   <= '0;
        end else if (ev.strobe) begin
            // Extended flag is part of the match
            case ({ev.extended, ev.code})
                // Player 1, arrows need E0
                {1'b1, arcade_keys_pkg::sc_up}:    key_joy1[arcade_keys_pkg::joy_up]    <= level;
                {1'b1, arcade_keys_pkg::sc_down}:  key_joy1[arcade_keys_pkg::joy_down]  <= level;
                {1'b1, arcade_keys_pkg::sc_left}:  key_joy1[arcade_keys_pkg::joy_left]  <= level;
                {1'b1, arcade_keys_pkg::sc_right}: key_joy1[arcade_keys_pkg::joy_right] <= level;
                {1'b0, arcade_keys_pkg::sc_lctrl}: key_joy1[arcade_keys_pkg::joy_but1]  <= level;
                {1'b0, arcade_keys_pkg::sc_lalt}:  key_joy1[arcade_keys_pkg::joy_but2]  <= level;
                {1'b0, arcade_keys_pkg::sc_space}: key_joy1[arcade_keys_pkg::joy_but3]  <= level;
                // Player 2 on the letter block
                {1'b0, arcade_keys_pkg::sc_r}: key_joy2[arcade_keys_pkg::joy_up]    <= level;
                {1'b0, arcade_keys_pkg::sc_f}: key_joy2[arcade_keys_pkg::joy_down]  <= level;
                {1'b0, arcade_keys_pkg::sc_d}: key_joy2[arcade_keys_pkg::joy_left]  <= level;
                {1'b0, arcade_keys_pkg::sc_g}: key_joy2[arcade_keys_pkg::joy_right] <= level;
                {1'b0, arcade_keys_pkg::sc_a}: key_joy2[arcade_keys_pkg::joy_but1]  <= level;
                {1'b0, arcade_keys_pkg::sc_s}: key_joy2[arcade_keys_pkg::joy_but2]  <= level;
                {1'b0, arcade_keys_pkg::sc_q}: key_joy2[arcade_keys_pkg::joy_but3]  <= level;
                // Coins
                {1'b0, arcade_keys_pkg::sc_5},
                {1'b0, arcade_keys_pkg::sc_f3}: key_coin[arcade_keys_pkg::p1] <= level;
                {1'b0, arcade_keys_pkg::sc_6}:  key_coin[arcade_keys_pkg::p2] <= level;
                // Starts
                {1'b0, arcade_keys_pkg::sc_1},
                {1'b0, arcade_keys_pkg::sc_f1}: key_start[arcade_keys_pkg::p1] <= level;
                {1'b0, arcade_keys_pkg::sc_2},
                {1'b0, arcade_keys_pkg::sc_f2}: key_start[arcade_keys_pkg::p2] <= level;
                {1'b0, arcade_keys_pkg::sc_p},
                {1'b0, arcade_keys_pkg::sc_f4}: key_pause <= level;
                // Layer enables on F7..F10
                {1'b0, arcade_keys_pkg::sc_f7}:  key_gfx[arcade_keys_pkg::gfx_char] <= level;
                {1'b0, arcade_keys_pkg::sc_f8}:  key_gfx[arcade_keys_pkg::gfx_scr1] <= level;
                {1'b0, arcade_keys_pkg::sc_f9}:  key_gfx[arcade_keys_pkg::gfx_scr2] <= level;
                {1'b0, arcade_keys_pkg::sc_f10}: key_gfx[arcade_keys_pkg::gfx_obj]  <= level;
                default: ;   // Unmapped key
            endcase
        end
    end

endmodule

`default_nettype wire

//--- arcade_keyboard.f
ps2_pkg.sv
arcade_keys_pkg.sv
key_event_if.sv
ps2_rx.sv
ps2_scan_tracker.sv
arcade_key_map.sv
arcade_keyboard.sv
arcade_keyboard_checker.sv
tb_arcade_keyboard.sv

//--- arcade_keyboard.sv
// PS/2 keyboard to arcade controls
`default_nettype none

module arcade_keyboard #(
    parameter int FILTER_LEN = 8,     // Clock filter run length
    parameter int IDLE_LIMIT = 4096   // Partial frame timeout
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    ps2_clk,
    input  wire                    ps2_data,
    output arcade_keys_pkg::joy_t  key_joy1,
    output arcade_keys_pkg::joy_t  key_joy2,
    output arcade_keys_pkg::pair_t key_start,
    output arcade_keys_pkg::pair_t key_coin,
    output logic                   key_pause,
    output arcade_keys_pkg::gfx_t  key_gfx
);

    ps2_pkg::scan_code_t byte_data;
    logic                byte_valid;
    logic                byte_error;

    key_event_if ev_if ();   // Tracker to key map

    ps2_rx #(
        .FILTER_LEN (FILTER_LEN),
        .IDLE_LIMIT (IDLE_LIMIT)
    ) u_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_error (byte_error)
    );

    ps2_scan_tracker u_tracker (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_error (byte_error),
        .ev         (ev_if.src)
    );

    arcade_key_map u_key_map (
        .clk       (clk),
        .rst       (rst),
        .ev        (ev_if.dst),
        .key_joy1  (key_joy1),
        .key_joy2  (key_joy2),
        .key_start (key_start),
        .key_coin  (key_coin),
        .key_pause (key_pause),
        .key_gfx   (key_gfx)
    );

endmodule

`default_nettype wire

//--- arcade_keyboard_checker.sv
// Event stream and reset assertions
`default_nettype none

module arcade_keyboard_checker (
    input wire                      clk,
    input wire                      rst,
    input wire                      byte_valid,
    input wire                      byte_error,
    input wire                      ev_strobe,
    input wire ps2_pkg::scan_code_t ev_code,
    input wire [28:0]               outs      // All arcade outputs packed
);

    int n_errors = 0;   // Failed assertions so far

    // Prefixes are absorbed by the tracker, never forwarded
    no_prefix_event: assert property (@(posedge clk) disable iff (rst)
        ev_strobe |-> (ev_code != ps2_pkg::prefix_ext && ev_code != ps2_pkg::prefix_break))
        else begin
            n_errors++;
            $error("key event strobe carries prefix byte %h", ev_code);
        end

    // One frame gives one verdict
    valid_error_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(byte_valid && byte_error))
        else begin
            n_errors++;
            $error("byte_valid and byte_error high in the same cycle");
        end

    reset_clears_outputs: assert property (@(posedge clk)
        rst |=> (outs == '0))
        else begin
            n_errors++;
            $error("outputs not cleared after reset, got %h", outs);
        end

endmodule

// Tracker side, no outputs here
bind ps2_scan_tracker arcade_keyboard_checker i_tracker_checker (
    .clk        (clk),
    .rst        (rst),
    .byte_valid (byte_valid),
    .byte_error (byte_error),
    .ev_strobe  (ev.strobe),
    .ev_code    (ev.code),
    .outs       (29'd0)
);

// Key map side, receiver pulses not visible
bind arcade_key_map arcade_keyboard_checker i_key_map_checker (
    .clk        (clk),
    .rst        (rst),
    .byte_valid (1'b0),
    .byte_error (1'b0),
    .ev_strobe  (ev.strobe),
    .ev_code    (ev.code),
    .outs       ({key_joy1, key_joy2, key_start, key_coin, key_pause, key_gfx})
);

`default_nettype wire

//--- arcade_keyboard_input.txt
# name byte bad_parity joy1 joy2 start coin pause gfx
# Values in hex, expected outputs after the frame has settled
coin1_f3_make      04 0 000 000 0 1 0 0
coin1_break_prefix F0 0 000 000 0 1 0 0
coin1_f3_break     04 0 000 000 0 0 0 0
keypad8_no_ext     75 0 000 000 0 0 0 0
up_ext_prefix      E0 0 000 000 0 0 0 0
up_make            75 0 008 000 0 0 0 0
p2_left_make       23 0 008 002 0 0 0 0
p2_but3_make       15 0 008 042 0 0 0 0
p1_but1_make       14 0 018 042 0 0 0 0
gfx_f7_make        83 0 018 042 0 0 0 1
gfx_f10_make       09 0 018 042 0 0 0 9
start1_f1_make     05 0 018 042 1 0 0 9
pause_f4_make      0C 0 018 042 1 0 1 9
enter_unmapped     5A 0 018 042 1 0 1 9
up_rel_ext_prefix  E0 0 018 042 1 0 1 9
up_rel_brk_prefix  F0 0 018 042 1 0 1 9
up_break           75 0 010 042 1 0 1 9
coin1_bad_parity   2E 1 010 042 1 0 1 9
brk_prefix_good    F0 0 010 042 1 0 1 9
brk_prefix_bad     F0 1 010 042 1 0 1 9
space_after_error  29 0 050 042 1 0 1 9
p2_left_brk_prefix F0 0 050 042 1 0 1 9
p2_left_break      23 0 050 040 1 0 1 9
coin2_make         36 0 050 040 1 2 1 9

//--- arcade_keys_pkg.sv
// Arcade control types and key codes
`default_nettype none

package arcade_keys_pkg;

    typedef logic [9:0] joy_t;   // Bits 7..9 spare
    typedef logic [1:0] pair_t;  // Player 1 in bit 0
    typedef logic [3:0] gfx_t;   // Layer enables

    // Joystick bit positions
    localparam int joy_right = 0;
    localparam int joy_left  = 1;
    localparam int joy_down  = 2;
    localparam int joy_up    = 3;
    localparam int joy_but1  = 4;
    localparam int joy_but2  = 5;
    localparam int joy_but3  = 6;

    localparam int p1 = 0;
    localparam int p2 = 1;

    // Graphics layers
    localparam int gfx_char = 0;
    localparam int gfx_scr1 = 1;
    localparam int gfx_scr2 = 2;
    localparam int gfx_obj  = 3;

    // Arrows, extended only
    localparam ps2_pkg::scan_code_t sc_up    = 8'h75;
    localparam ps2_pkg::scan_code_t sc_down  = 8'h72;
    localparam ps2_pkg::scan_code_t sc_left  = 8'h6B;
    localparam ps2_pkg::scan_code_t sc_right = 8'h74;

    // Player 1 buttons
    localparam ps2_pkg::scan_code_t sc_lctrl = 8'h14;
    localparam ps2_pkg::scan_code_t sc_lalt  = 8'h11;
    localparam ps2_pkg::scan_code_t sc_space = 8'h29;

    // Player 2 letters
    localparam ps2_pkg::scan_code_t sc_r = 8'h2D;
    localparam ps2_pkg::scan_code_t sc_f = 8'h2B;
    localparam ps2_pkg::scan_code_t sc_d = 8'h23;
    localparam ps2_pkg::scan_code_t sc_g = 8'h34;
    localparam ps2_pkg::scan_code_t sc_a = 8'h1C;
    localparam ps2_pkg::scan_code_t sc_s = 8'h1B;
    localparam ps2_pkg::scan_code_t sc_q = 8'h15;

    // Coins, starts, pause
    localparam ps2_pkg::scan_code_t sc_5  = 8'h2E;
    localparam ps2_pkg::scan_code_t sc_6  = 8'h36;
    localparam ps2_pkg::scan_code_t sc_1  = 8'h16;
    localparam ps2_pkg::scan_code_t sc_2  = 8'h1E;
    localparam ps2_pkg::scan_code_t sc_p  = 8'h4D;
    localparam ps2_pkg::scan_code_t sc_f1 = 8'h05;
    localparam ps2_pkg::scan_code_t sc_f2 = 8'h06;
    localparam ps2_pkg::scan_code_t sc_f3 = 8'h04;
    localparam ps2_pkg::scan_code_t sc_f4 = 8'h0C;

    // Layer toggles
    localparam ps2_pkg::scan_code_t sc_f7  = 8'h83;
    localparam ps2_pkg::scan_code_t sc_f8  = 8'h0A;
    localparam ps2_pkg::scan_code_t sc_f9  = 8'h01;
    localparam ps2_pkg::scan_code_t sc_f10 = 8'h09;

endpackage

`default_nettype wire

//--- key_event_if.sv
// Decoded key event channel
`default_nettype none

interface key_event_if;

    ps2_pkg::scan_code_t code;  // Final byte of the sequence
    logic extended;             // E0 seen before code
    logic released;             // F0 seen before code
    logic strobe;               // One cycle, qualifies the rest

    modport src (
        output code,
        output extended,
        output released,
        output strobe
    );

    modport dst (
        input code,
        input extended,
        input released,
        input strobe
    );

endinterface

`default_nettype wire

//--- ps2_pkg.sv
// PS/2 protocol definitions
`default_nettype none

package ps2_pkg;

    // One scan byte, set 2
    typedef logic [7:0] scan_code_t;

    // Prefix bytes
    localparam scan_code_t prefix_ext   = 8'hE0;  // Extended key follows
    localparam scan_code_t prefix_break = 8'hF0;  // Key release follows

    // Start, 8 data, odd parity, stop
    localparam int frame_bits = 11;

    // Bit positions, LSB first on the wire
    localparam int start_pos = 0;
    localparam int data_lsb  = 1;
    localparam int par_pos   = 9;
    localparam int stop_pos  = 10;

    // Whole frame as received
    typedef logic [frame_bits-1:0] frame_t;

endpackage

`default_nettype wire

//--- ps2_rx.sv
// PS/2 frame receiver
`default_nettype none

module ps2_rx #(
    parameter int FILTER_LEN = 8,
    parameter int IDLE_LIMIT = 4096
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 ps2_clk,
    input  wire                 ps2_data,
    output ps2_pkg::scan_code_t byte_data,
    output logic                byte_valid,
    output logic                byte_error
);

    localparam int FILT_W = $clog2(FILTER_LEN + 1);
    localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);
    localparam int CNT_W  = $clog2(ps2_pkg::frame_bits + 1);

    logic [1:0]        clk_sync;   // Two-flop synchronizers
    logic [1:0]        data_sync;
    logic              clk_filt;   // Debounced PS/2 clock
    logic [FILT_W-1:0] filt_cnt;   // Run of samples differing from clk_filt
    logic              accept;
    logic              fall;
    logic [CNT_W-1:0]  bit_cnt;
    logic [IDLE_W-1:0] idle_cnt;
    logic              last_bit;
    logic              frame_ok;
    logic [ps2_pkg::frame_bits-2:0] shreg;   // Bits received so far
    ps2_pkg::frame_t   frame;      // Shift register with the current bit in

    // New level held for FILTER_LEN samples
    assign accept = (clk_sync[1] != clk_filt) && (filt_cnt == FILT_W'(FILTER_LEN - 1));
    assign fall   = accept && !clk_sync[1];   // Internal falling edge

    // Bits arrive LSB first, so shift in from the top
    assign frame    = {data_sync[1], shreg};
    assign last_bit = bit_cnt == CNT_W'(ps2_pkg::frame_bits - 1);

    // Start low, odd parity over data and parity, stop high
    assign frame_ok = !frame[ps2_pkg::start_pos]
                      && (^frame[ps2_pkg::par_pos:ps2_pkg::data_lsb])
                      && frame[ps2_pkg::stop_pos];

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;   // Bus idles high
            data_sync <= 2'b11;
            clk_filt  <= 1'b1;
            filt_cnt  <= '0;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            if (clk_sync[1] == clk_filt) begin
                filt_cnt <= '0;   // Glitch gone, start over
            end else if (accept) begin
                clk_filt <= clk_sync[1];
                filt_cnt <= '0;
            end else begin
                filt_cnt <= filt_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            byte_valid <= 1'b0;
            byte_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            byte_error <= 1'b0;

            // Any filtered edge restarts the idle timer
            if (accept) begin
                idle_cnt <= '0;
            end else if (idle_cnt != IDLE_W'(IDLE_LIMIT)) begin
                idle_cnt <= idle_cnt + 1'b1;   // Saturates
            end

            if (fall) begin
                if (last_bit) begin
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                    byte_error <= !frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (idle_cnt == IDLE_W'(IDLE_LIMIT)) begin
                bit_cnt <= '0;   // Drop stale partial frame
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (fall) begin
            shreg <= frame[ps2_pkg::frame_bits-1:1];
        end
        if (fall && last_bit) begin
            byte_data <= frame[ps2_pkg::data_lsb +: 8];
        end
    end

endmodule

`default_nettype wire

//--- ps2_scan_tracker.sv
// Scan code prefix tracker
`default_nettype none

module ps2_scan_tracker (
    input  wire                 clk,
    input  wire                 rst,
    input  wire ps2_pkg::scan_code_t byte_data,
    input  wire                 byte_valid,
    input  wire                 byte_error,
    key_event_if.src            ev
);

    typedef enum logic [1:0] {
        st_idle,
        st_ext,
        st_brk,
        st_ext_brk
    } prefix_state_t;

    prefix_state_t state;
    logic          is_ext;
    logic          is_brk;
    logic          ext_seen;
    logic          brk_seen;

    assign is_ext   = byte_data == ps2_pkg::prefix_ext;
    assign is_brk   = byte_data == ps2_pkg::prefix_break;
    assign ext_seen = (state == st_ext) || (state == st_ext_brk);
    assign brk_seen = (state == st_brk) || (state == st_ext_brk);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            ev.strobe <= 1'b0;
        end else begin
            ev.strobe <= byte_valid && !is_ext && !is_brk;   // Prefixes never emit
            if (byte_error) begin
                state <= st_idle;   // Forget half-seen sequence
            end else if (byte_valid) begin
                if (is_ext || is_brk) begin
                    case ({ext_seen | is_ext, brk_seen | is_brk})
                        2'b10:   state <= st_ext;
                        2'b01:   state <= st_brk;
                        default: state <= st_ext_brk;
                    endcase
                end else begin
                    state <= st_idle;   // Sequence complete
                end
            end
        end
    end

    // Event payload, valid with strobe
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            ev.code     <= byte_data;
            ev.extended <= ext_seen;
            ev.released <= brk_seen;
        end
    end

endmodule

`default_nettype wire

//--- tb_arcade_keyboard.sv
// Arcade keyboard testbench
`default_nettype none

module tb_arcade_keyboard;

    localparam int half_period = 16;   // clk cycles per PS/2 clock phase
    localparam int idle_gap    = 64;   // Settle time after stop bit

    logic clk;
    logic rst;
    logic ps2_clk;
    logic ps2_data;

    arcade_keys_pkg::joy_t  key_joy1;
    arcade_keys_pkg::joy_t  key_joy2;
    arcade_keys_pkg::pair_t key_start;
    arcade_keys_pkg::pair_t key_coin;
    logic                   key_pause;
    arcade_keys_pkg::gfx_t  key_gfx;

    // Vectors from the data file
    string       name_q[$];
    logic [7:0]  byte_q[$];
    logic        par_q[$];
    logic [28:0] exp_q[$];     // {joy1, joy2, start, coin, pause, gfx}

    int n_pass;
    int n_fail;
    int n_assert;   // Failed bound assertions
    int cycles;
    int limit;

    arcade_keyboard i_arcade_keyboard (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .key_joy1  (key_joy1),
        .key_joy2  (key_joy2),
        .key_start (key_start),
        .key_coin  (key_coin),
        .key_pause (key_pause),
        .key_gfx   (key_gfx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d clock cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic load_vectors;
        int          fd;
        string       line;
        string       nm;
        logic [7:0]  b;
        logic        p;
        logic [9:0]  j1;
        logic [9:0]  j2;
        logic [1:0]  st;
        logic [1:0]  co;
        logic        pa;
        logic [3:0]  gf;
        fd = $fopen("arcade_keyboard_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file arcade_keyboard_input.txt");
            n_fail++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment lines stop after the first field
                if ($sscanf(line, "%s %h %h %h %h %h %h %h %h",
                            nm, b, p, j1, j2, st, co, pa, gf) == 9) begin
                    name_q.push_back(nm);
                    byte_q.push_back(b);
                    par_q.push_back(p);
                    exp_q.push_back({j1, j2, st, co, pa, gf});
                end
            end
            $fclose(fd);
        end
    endtask

    // Start, data LSB first, odd parity, stop
    task automatic send_frame(input logic [7:0] data, input logic bad_par);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data <= bits[i];        // Data moves while clock high
            repeat (half_period) @(posedge clk);
            ps2_clk <= 1'b0;            // Receiver samples here
            repeat (half_period) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        repeat (idle_gap) @(posedge clk);
    endtask

    task automatic check_outputs(input string name, input logic [28:0] exp);
        int errs;
        errs = 0;
        if (key_joy1 !== exp[28:19]) begin
            $display("mismatch %s key_joy1 expected %h actual %h", name, exp[28:19], key_joy1);
            errs++;
        end
        if (key_joy2 !== exp[18:9]) begin
            $display("mismatch %s key_joy2 expected %h actual %h", name, exp[18:9], key_joy2);
            errs++;
        end
        if (key_start !== exp[8:7]) begin
            $display("mismatch %s key_start expected %h actual %h", name, exp[8:7], key_start);
            errs++;
        end
        if (key_coin !== exp[6:5]) begin
            $display("mismatch %s key_coin expected %h actual %h", name, exp[6:5], key_coin);
            errs++;
        end
        if (key_pause !== exp[4]) begin
            $display("mismatch %s key_pause expected %h actual %h", name, exp[4], key_pause);
            errs++;
        end
        if (key_gfx !== exp[3:0]) begin
            $display("mismatch %s key_gfx expected %h actual %h", name, exp[3:0], key_gfx);
            errs++;
        end
        if (errs == 0) begin
            n_pass++;
            $display("test %s ok", name);
        end else begin
            n_fail++;
            $display("test %s failed with %0d wrong outputs", name, errs);
        end
    endtask

    initial begin
        rst      = 1'b1;
        ps2_clk  = 1'b1;   // Bus idles high
        ps2_data = 1'b1;
        n_pass   = 0;
        n_fail   = 0;
        n_assert = 0;
        cycles   = 0;
        load_vectors();
        // Two frame lengths per line plus reset margin
        limit = 2 * name_q.size() * (ps2_pkg::frame_bits * 2 * half_period + idle_gap) + 200;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_outputs("after_reset", '0);

        foreach (name_q[k]) begin
            send_frame(byte_q[k], par_q[k]);
            check_outputs(name_q[k], exp_q[k]);
        end

        // Bound checkers count their own failures
        n_assert = i_arcade_keyboard.u_tracker.i_tracker_checker.n_errors
                   + i_arcade_keyboard.u_key_map.i_key_map_checker.n_errors;

        $display("tests passed %0d failed %0d assertion failures %0d",
                 n_pass, n_fail, n_assert);
        if (n_fail == 0 && n_assert == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
